//--- build.f
+incdir+.
board_pkg.sv
bus_arbiter.sv
host_port_bridge.sv
fm_tone_xmit.sv
periph_fabric.sv
board_top.sv
tb_clk_gen.sv
board_tb.sv

//--- Bender.yml
package:
  name: board_bus

export_include_dirs:
  - .

sources:
  - board_pkg.sv
  - bus_arbiter.sv
  - host_port_bridge.sv
  - fm_tone_xmit.sv
  - periph_fabric.sv
  - board_top.sv
  - target: test
    files:
      - tb_clk_gen.sv
      - board_tb.sv

//--- board_tb.sv
// ======================================================================
// Board bus subsystem testbench
// Stimulus table from the external port and the host bridge, LED,
// contention, FM tone and unmapped address checks
// ======================================================================
`timescale 1ns/1ps
`include "board_defines.svh"

module board_tb import board_pkg::*; ();

   localparam int M_EXT = 0, M_HOST = 1, M_BOTH = 2; // Master column codes

   logic       CLK_I, arst_n;
   bus_req_t   ext_req;
   bus_rsp_t   ext_rsp;
   logic       host_addr_stb_n, host_data_stb_n, host_write_n;
   logic [7:0] host_wdata, host_rdata;
   logic       host_rdata_en, host_wait, antenna;
   logic [3:0] leds;

   // Stimulus table, one entry per row in each queue
   string       t_name[$];
   int          t_mst[$];
   logic        t_we[$];
   logic [7:0]  t_adr[$];
   logic [31:0] t_wdat[$];
   logic [31:0] t_exp[$];
   logic [3:0]  led_model;  // Expected LED register
   bus_master_t last_mst;   // Master served most recently

   tb_clk_gen tb_clk_gen_inst (.CLK_I, .arst_n);

   board_top board_top_inst (
      .CLK_I, .arst_n, .ext_req, .ext_rsp,
      .host_addr_stb_n, .host_data_stb_n, .host_write_n,
      .host_wdata, .host_rdata, .host_rdata_en, .host_wait,
      .leds, .antenna
   );

   task automatic fail_stop(input string why);
      $display("%s", why);
      $display("Test failed");
      $fatal(1, "Simulation stopped");
   endtask

   task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] act);
      assert (act === exp)
      else fail_stop($sformatf("ERROR %s expected %h actual %h", name, exp, act));
   endtask

   // Row with expected value from the bus rules
   task automatic add_row(input string name, input int mst, input logic we,
                          input logic [7:0] adr, input logic [31:0] wdat);
      bus_master_t second; // Master whose cycle ends last in this row
      second = (mst == M_HOST) ? MST_HOST : MST_EXT;
      if (mst == M_BOTH)
         second = last_mst; // Round robin loser goes second
      if (we && adr[`DEC_LED_BIT])
         led_model = (mst == M_BOTH && second == MST_HOST) ? ~wdat[3:0] : wdat[3:0];
      last_mst = second;
      t_name.push_back(name);
      t_mst.push_back(mst);
      t_we.push_back(we);
      t_adr.push_back(adr);
      t_wdat.push_back(wdat);
      // Writes checked on the LED pins, unmapped reads give zero
      t_exp.push_back((we || adr[`DEC_LED_BIT]) ? {28'h0, led_model} : 32'h0);
   endtask

   task automatic build_table();
      int   mst;
      logic we;
      led_model = 4'h0;
      last_mst  = MST_HOST; // External port first after reset
      add_row("ext_led_wr", M_EXT, 1'b1, 8'h04, $urandom);
      add_row("ext_led_rd", M_EXT, 1'b0, 8'h04, 32'h0);
      add_row("host_led_rd", M_HOST, 1'b0, 8'h04, 32'h0);
      add_row("host_led_wr", M_HOST, 1'b1, 8'h04, $urandom);
      add_row("ext_led_rd2", M_EXT, 1'b0, 8'h04, 32'h0);
      add_row("both_led_wr_a", M_BOTH, 1'b1, 8'h04, $urandom);
      add_row("both_led_wr_b", M_BOTH, 1'b1, 8'h04, $urandom);
      add_row("host_led_wr2", M_HOST, 1'b1, 8'h04, $urandom);
      add_row("both_led_wr_c", M_BOTH, 1'b1, 8'h04, $urandom);
      add_row("ext_unmapped_rd", M_EXT, 1'b0, 8'h00, 32'h0);
      add_row("host_unmapped_rd", M_HOST, 1'b0, 8'h08, 32'h0);
      for (int i = 0; i < 8; i++) begin
         mst = $urandom_range(2);
         we  = (mst == M_BOTH) || ($urandom_range(1) == 1); // Contention rows write
         add_row($sformatf("rand_%0d", i), mst, we, ($urandom_range(1) == 1) ? 8'h04 : 8'h01,
                 $urandom);
      end
   endtask

   task automatic ext_access(input logic we, input logic [7:0] adr, input logic [31:0] wdat,
                             output logic [31:0] rdat);
      int n = 0;
      @(posedge CLK_I);
      ext_req <= '{stb: 1'b1, we: we, adr: adr, dat: wdat};
      do begin
         @(negedge CLK_I);
         n++;
         if (n > 50)
            fail_stop("External port got no ack within 50 cycles");
      end while (!ext_rsp.ack);
      rdat = ext_rsp.dat;
      @(posedge CLK_I);
      ext_req <= '0; // Drop stb after the ack cycle
   endtask

   task automatic wait_host_wait(input logic level);
      int n = 0;
      do begin
         @(negedge CLK_I);
         n++;
         if (n > 50)
            fail_stop($sformatf("host_wait did not go to %0b within 50 cycles", level));
      end while (host_wait !== level);
   endtask

   // One host strobe, address or data, held until host_wait
   task automatic host_strobe(input logic addr_cyc, input logic wr, input logic [7:0] wdat,
                              output logic [7:0] rdat);
      @(posedge CLK_I);
      host_write_n <= ~wr;
      host_wdata   <= wdat;
      if (addr_cyc)
         host_addr_stb_n <= 1'b0;
      else
         host_data_stb_n <= 1'b0;
      wait_host_wait(1'b1);
      rdat = host_rdata;
      if (!wr)
         check_value("host_rdata_en", 32'h1, {31'h0, host_rdata_en});
      @(posedge CLK_I);
      host_addr_stb_n <= 1'b1;
      host_data_stb_n <= 1'b1;
      host_write_n    <= 1'b1;
      wait_host_wait(1'b0);
   endtask

   task automatic host_access(input logic we, input logic [7:0] adr, input logic [7:0] wdat,
                              output logic [31:0] rdat);
      logic [7:0] r8;
      host_strobe(1'b1, 1'b1, adr, r8); // Load address register
      host_strobe(1'b0, we, wdat, r8);
      rdat = {24'h0, r8};
   endtask

   // Both requests reach the arbiter in the same cycle
   task automatic contend(input logic [7:0] adr, input logic [31:0] wdat);
      logic [7:0]  r8;
      logic [31:0] r32;
      host_strobe(1'b1, 1'b1, adr, r8);
      fork
         host_strobe(1'b0, 1'b1, ~wdat[7:0], r8);
         begin
            repeat (`SYNC_STAGES + 1) @(posedge CLK_I); // Host strobe sync delay
            ext_access(1'b1, adr, wdat, r32);
         end
      join
   endtask

   initial begin
      logic [31:0] rdat;
      logic [7:0]  r8;
      int          n, edges, toggles;
      logic        prev;
      ext_req         = '0;
      host_addr_stb_n = 1'b1;
      host_data_stb_n = 1'b1;
      host_write_n    = 1'b1;
      host_wdata      = 8'h00;
      void'($urandom(63));
      build_table();
      n = 0;
      do begin
         @(negedge CLK_I);
         n++;
         if (n > 10)
            fail_stop("Reset was never released");
      end while (!arst_n);
      check_value("reset_state", 32'h0,
                  {24'h0, leds, antenna, host_wait, host_rdata_en, ext_rsp.ack});
      // Host address register write and read back
      host_strobe(1'b1, 1'b1, 8'h5A, r8);
      host_strobe(1'b1, 1'b0, 8'h00, r8);
      check_value("host_addr_rb", 32'h5A, {24'h0, r8});
      for (int i = 0; i < t_name.size(); i++) begin
         case (t_mst[i])
            M_EXT:   ext_access(t_we[i], t_adr[i], t_wdat[i], rdat);
            M_HOST:  host_access(t_we[i], t_adr[i], t_wdat[i][7:0], rdat);
            default: contend(t_adr[i], t_wdat[i]);
         endcase
         @(negedge CLK_I);
         check_value(t_name[i], t_exp[i], t_we[i] ? {28'h0, leds} : rdat);
      end
      // FM tone, 0x2000 step gives one period per 8 cycles
      ext_access(1'b1, 8'h10, 32'h2000, rdat);
      @(negedge CLK_I);
      edges = 0;
      prev  = antenna;
      repeat (256) begin
         @(negedge CLK_I);
         if (antenna && !prev)
            edges++;
         prev = antenna;
      end
      assert (edges >= 31 && edges <= 33)
      else fail_stop($sformatf("ERROR fm_edges expected 32 actual %0d", edges));
      ext_access(1'b1, 8'h10, 32'h0, rdat); // Silence
      @(negedge CLK_I);
      toggles = 0;
      prev    = antenna;
      repeat (32) begin
         @(negedge CLK_I);
         if (antenna !== prev)
            toggles++;
      end
      check_value("fm_stopped", 32'h0, toggles);
      ext_access(1'b0, 8'h10, 32'h0, rdat);
      check_value("fm_rd_antenna", {31'h0, prev}, rdat);
      $display("Test passed");
      $finish;
   end

endmodule

//--- tb_clk_gen.sv
// ======================================================================
// Testbench clock and reset source
// 100 ns clock, active low reset held for 3 cycles
// ======================================================================
`timescale 1ns/1ps

module tb_clk_gen (
   output logic CLK_I,
   output logic arst_n
);

   initial begin
      CLK_I = 1'b0;
      forever #50 CLK_I = ~CLK_I; // 100 ns period
   end

   initial begin
      arst_n = 1'b0;
      repeat (3) @(posedge CLK_I);
      arst_n <= 1'b1; // Released on the third rising edge
   end

endmodule

//--- board_top.sv
// ======================================================================
// Board bus subsystem top level
// Host bridge and external port share the bus through the
// arbiter, fabric serves LEDs, FM transmitter and default target
// ======================================================================
`timescale 1ns/1ps

module board_top import board_pkg::*; (
   input  logic       CLK_I,
   input  logic       arst_n,
   input  bus_req_t   ext_req,         // Core stand-in
   output bus_rsp_t   ext_rsp,
   input  logic       host_addr_stb_n, // Host parallel port
   input  logic       host_data_stb_n,
   input  logic       host_write_n,
   input  logic [7:0] host_wdata,
   output logic [7:0] host_rdata,
   output logic       host_rdata_en,
   output logic       host_wait,
   output logic [3:0] leds,
   output logic       antenna          // FM out
);

   bus_req_t host_req, shared_req, fm_req;
   bus_rsp_t host_rsp, shared_rsp, fm_rsp;

   host_port_bridge host_port_bridge_inst (
      .CLK_I, .arst_n,
      .host_addr_stb_n, .host_data_stb_n, .host_write_n,
      .host_wdata, .host_rdata, .host_rdata_en, .host_wait,
      .host_req, .host_rsp
   );

   bus_arbiter bus_arbiter_inst (
      .CLK_I, .arst_n,
      .ext_req, .host_req,
      .ext_rsp, .host_rsp,
      .shared_req, .shared_rsp
   );

   periph_fabric periph_fabric_inst (
      .CLK_I, .arst_n,
      .shared_req, .shared_rsp,
      .fm_req, .fm_rsp,
      .leds
   );

   fm_tone_xmit fm_tone_xmit_inst (
      .CLK_I, .arst_n, .fm_req, .fm_rsp, .antenna
   );

endmodule

//--- periph_fabric.sv
// ======================================================================
// Peripheral fabric
// One-hot address decode, LED register, default responder for
// unmapped addresses, merged acknowledge and read data
// ======================================================================
`timescale 1ns/1ps
`include "board_defines.svh"

module periph_fabric import board_pkg::*; (
   input  logic       CLK_I,
   input  logic       arst_n,
   input  bus_req_t   shared_req,
   output bus_rsp_t   shared_rsp,
   output bus_req_t   fm_req,
   input  bus_rsp_t   fm_rsp,
   output logic [3:0] leds
);

   logic led_sel, fm_sel, def_sel;
   logic led_ack_q, def_ack_q;

   // Decode, LED bit has priority
   assign led_sel = shared_req.adr[`DEC_LED_BIT];
   assign fm_sel  = shared_req.adr[`DEC_FM_BIT] & ~led_sel;
   assign def_sel = ~led_sel & ~fm_sel; // Nothing mapped here

   // FM target sees its own strobe
   always_comb begin
      fm_req     = shared_req;
      fm_req.stb = shared_req.stb & fm_sel;
   end

   // LED register and default responder
   always_ff @(posedge CLK_I or negedge arst_n) begin
      if (!arst_n) begin
         leds      <= '0;
         led_ack_q <= 1'b0;
         def_ack_q <= 1'b0;
      end else begin
         led_ack_q <= shared_req.stb & led_sel & ~led_ack_q;
         def_ack_q <= shared_req.stb & def_sel & ~def_ack_q; // Keeps the bus alive
         if (shared_req.stb && led_sel && shared_req.we && !led_ack_q)
            leds <= shared_req.dat[3:0];
      end
   end

   // Merge, only the acking target puts data on the bus
   always_comb begin
      shared_rsp.ack = led_ack_q | def_ack_q | fm_rsp.ack;
      shared_rsp.dat = ({`BUS_DW{led_ack_q}} & {{(`BUS_DW-4){1'b0}}, leds})
                     | ({`BUS_DW{fm_rsp.ack}} & fm_rsp.dat);
   end

   // No target answers a strobe that is gone
   a_ack_needs_stb: assert property (@(posedge CLK_I) disable iff (!arst_n)
      shared_rsp.ack |-> shared_req.stb);

endmodule

//--- fm_tone_xmit.sv
// ======================================================================
// FM tone transmitter
// Phase accumulator with a writable increment register, antenna
// is the accumulator MSB and readable in bit 0
// ======================================================================
`timescale 1ns/1ps
`include "board_defines.svh"

module fm_tone_xmit import board_pkg::*; (
   input  logic     CLK_I,
   input  logic     arst_n,
   input  bus_req_t fm_req,  // stb already decoded
   output bus_rsp_t fm_rsp,
   output logic     antenna
);

   logic [`FM_ACC_W-2:0] incr_q; // Phase step
   logic [`FM_ACC_W-1:0] acc_q;  // Phase
   logic                 ack_q;
   logic                 wr_en;

   // One write per strobe
   assign wr_en = fm_req.stb & fm_req.we & ~ack_q;

   always_ff @(posedge CLK_I or negedge arst_n) begin
      if (!arst_n) begin
         incr_q <= '0; // Silent after reset
         acc_q  <= '0;
         ack_q  <= 1'b0;
      end else begin
         ack_q <= fm_req.stb & ~ack_q; // Single pulse per strobe
         acc_q <= acc_q + {1'b0, incr_q};
         if (wr_en)
            incr_q <= fm_req.dat[`FM_ACC_W-2:0];
      end
   end

   // Tone out, square wave at incr/2^FM_ACC_W of CLK_I
   assign antenna = acc_q[`FM_ACC_W-1];

   // Read returns antenna only
   assign fm_rsp = '{ack: ack_q, dat: {{(`BUS_DW-1){1'b0}}, antenna}};

endmodule

//--- host_port_bridge.sv
// ======================================================================
// Host parallel-port bridge
// EPP-like address and data strobes synchronized to CLK_I, an 8-bit
// address register, data strobes turned into shared bus cycles
// ======================================================================
`timescale 1ns/1ps
`include "board_defines.svh"

module host_port_bridge import board_pkg::*; (
   input  logic       CLK_I,
   input  logic       arst_n,
   input  logic       host_addr_stb_n, // Address strobe, active low
   input  logic       host_data_stb_n, // Data strobe, active low
   input  logic       host_write_n,    // Host writes when low
   input  logic [7:0] host_wdata,
   output logic [7:0] host_rdata,
   output logic       host_rdata_en,   // Bridge drives the data pins
   output logic       host_wait,       // Strobe accepted
   output bus_req_t   host_req,
   input  bus_rsp_t   host_rsp
);

   logic [`SYNC_STAGES-1:0][2:0] sync_q; // {addr_n, data_n, write_n} per stage
   logic        addr_act, data_act, host_wr;
   host_state_t state;
   logic [7:0]  addr_q;  // Host address register
   logic [7:0]  wdata_q; // Captured write byte
   logic [7:0]  rdata_q; // Captured read byte
   logic        cyc_we;  // Direction of the pending data cycle

   // Last synchronizer stage, active high
   assign addr_act = ~sync_q[`SYNC_STAGES-1][2];
   assign data_act = ~sync_q[`SYNC_STAGES-1][1];
   assign host_wr  = ~sync_q[`SYNC_STAGES-1][0];

   always_ff @(posedge CLK_I or negedge arst_n) begin
      if (!arst_n) begin
         sync_q <= '1; // All strobes idle
         state  <= IDLE;
         addr_q <= '0;
         cyc_we <= 1'b0;
      end else begin
         sync_q <= {sync_q[`SYNC_STAGES-2:0], host_addr_stb_n, host_data_stb_n, host_write_n};
         case (state)
            IDLE: begin
               if (addr_act) begin
                  if (host_wr) begin
                     addr_q <= host_wdata; // Address write
                     state  <= ADDR_WR;
                  end else begin
                     state  <= ADDR_RD;
                  end
               end else if (data_act) begin
                  cyc_we <= host_wr;
                  state  <= BUS_CYC;
               end
            end
            ADDR_WR, ADDR_RD: if (!addr_act) state <= IDLE;
            BUS_CYC:          if (host_rsp.ack) state <= HOLD_WAIT; // Latency set by arbiter
            HOLD_WAIT:        if (!data_act) state <= IDLE;
            default:          state <= IDLE;
         endcase
      end
   end

   // Data bytes
   always_ff @(posedge CLK_I) begin
      if (state == IDLE && !addr_act && data_act)
         wdata_q <= host_wdata; // Stable for several cycles by now
      if (state == BUS_CYC && host_rsp.ack)
         rdata_q <= host_rsp.dat[7:0];
   end

   // Bus master side, low byte zero-extended
   always_comb begin
      host_req.stb = (state == BUS_CYC);
      host_req.we  = cyc_we;
      host_req.adr = addr_q;
      host_req.dat = {{(`BUS_DW-8){1'b0}}, wdata_q};
   end

   // Host pin side
   assign host_wait     = (state == ADDR_WR) || (state == ADDR_RD) || (state == HOLD_WAIT);
   assign host_rdata_en = (state == ADDR_RD) || ((state == HOLD_WAIT) && !cyc_we);
   assign host_rdata    = (state == ADDR_RD) ? addr_q : rdata_q;

   // Request held steady until the bus answers
   a_req_hold: assert property (@(posedge CLK_I) disable iff (!arst_n)
      host_req.stb && !host_rsp.ack |=> host_req.stb && $stable(host_req));

endmodule

//--- bus_arbiter.sv
// ======================================================================
// Two-master round-robin bus arbiter
// Registered grant held until the target acknowledge, stb of the
// losing master masked, ack routed back to the owner only
// ======================================================================
`timescale 1ns/1ps

module bus_arbiter import board_pkg::*; (
   input  logic     CLK_I,
   input  logic     arst_n,
   input  bus_req_t ext_req,     // External core port
   input  bus_req_t host_req,    // Host bridge
   output bus_rsp_t ext_rsp,
   output bus_rsp_t host_rsp,
   output bus_req_t shared_req,  // To the fabric
   input  bus_rsp_t shared_rsp
);

   bus_master_t owner;       // Current grant
   bus_master_t last_served; // Round robin memory
   logic        busy;        // Grant is live

   // Grant FSM
   always_ff @(posedge CLK_I or negedge arst_n) begin
      if (!arst_n) begin
         owner       <= MST_EXT;
         last_served <= MST_HOST; // External port goes first
         busy        <= 1'b0;
      end else if (busy) begin
         // Release only on the ack cycle
         if (shared_rsp.ack) begin
            busy        <= 1'b0;
            last_served <= owner;
         end
      end else if (ext_req.stb && host_req.stb) begin
         // Contention, the one not served last wins
         owner <= (last_served == MST_EXT) ? MST_HOST : MST_EXT;
         busy  <= 1'b1;
      end else if (ext_req.stb) begin
         owner <= MST_EXT;
         busy  <= 1'b1;
      end else if (host_req.stb) begin
         owner <= MST_HOST;
         busy  <= 1'b1;
      end
   end

   // Forward granted request
   always_comb begin
      shared_req     = (owner == MST_HOST) ? host_req : ext_req;
      shared_req.stb = shared_req.stb & busy; // Nothing out before the grant
   end

   // Read data goes to both, ack only to the owner
   always_comb begin
      ext_rsp      = shared_rsp;
      host_rsp     = shared_rsp;
      ext_rsp.ack  = shared_rsp.ack & busy & (owner == MST_EXT);
      host_rsp.ack = shared_rsp.ack & busy & (owner == MST_HOST);
   end

   // Each ack answers a strobe of the master that gets it
   a_ack_to_owner: assert property (@(posedge CLK_I) disable iff (!arst_n)
      (!ext_rsp.ack || ext_req.stb) && (!host_rsp.ack || host_req.stb));

   // Grant locked for the whole cycle until ack
   a_grant_hold: assert property (@(posedge CLK_I) disable iff (!arst_n)
      shared_req.stb && !shared_rsp.ack |=> busy && $stable(owner));

endmodule

//--- board_pkg.sv
// ======================================================================
// Shared types of the board bus subsystem
// Bus request and response structs, bridge FSM states and
// the arbiter grant owner
// ======================================================================
`include "board_defines.svh"

package board_pkg;

   // Master to target, all fields held until ack
   typedef struct packed {
      logic                stb; // Cycle request
      logic                we;  // 1 = write
      logic [`BUS_AW-1:0]  adr; // Byte address
      logic [`BUS_DW-1:0]  dat; // Write data
   } bus_req_t;

   // Target to master
   typedef struct packed {
      logic                ack; // Single cycle pulse
      logic [`BUS_DW-1:0]  dat; // Read data, valid with ack
   } bus_rsp_t;

   // Host parallel-port bridge states
   typedef enum logic [2:0] {
      IDLE,
      ADDR_WR,   // Host writes address register
      ADDR_RD,   // Host reads address register back
      BUS_CYC,   // Bus cycle in flight
      HOLD_WAIT  // Done, waiting for strobe release
   } host_state_t;

   // Who owns the shared bus
   typedef enum logic {MST_EXT, MST_HOST} bus_master_t;

endpackage

//--- board_defines.svh
// ======================================================================
// Board bus subsystem parameters
// Bus widths, one-hot decode bit positions, FM accumulator width
// and host strobe synchronizer depth
// ======================================================================
`ifndef BOARD_DEFINES_SVH
`define BOARD_DEFINES_SVH

// Shared bus
`define BUS_DW 32 // Data width
`define BUS_AW 8  // Byte address width, matches host address register

// One-hot peripheral select bits in the address
`define DEC_LED_BIT 2 // LED register, wins over FM
`define DEC_FM_BIT  4 // FM tone transmitter

// FM phase accumulator, increment is one bit narrower
`define FM_ACC_W 16

// Host strobe synchronizer flops, at least 2
`define SYNC_STAGES 2

`endif
